// File: src.f
+incdir+rtl
rtl/panel_pkg.sv
rtl/disp_mode_fsm.sv
rtl/display_timer.sv
rtl/display_word_select.sv
rtl/seg_digit_driver.sv
rtl/rgb_status_led.sv
rtl/status_panel_top.sv
tests/panel_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the status panel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f src.f -o sim_tb_top

./obj_dir/sim_tb_top | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/tb_top.sv
`include "panel_defines.svh"

module tb_top
    import panel_pkg::*;
();

    localparam int FRAME      = `PANEL_DIGITS * `PANEL_SCAN_DIV;  // one full scan
    localparam int CHECK_LEN  = 3 * FRAME + 2;
    localparam int T1_LEN     = 8 + CHECK_LEN;
    localparam int T2_LEN     = FRAME + 16 * `PANEL_SCROLL_DIV + 8;
    localparam int T3_LEN     = 6 * (24 + CHECK_LEN);
    localparam int T4_LEN     = 10 * (2 + CHECK_LEN);
    localparam int T5_LEN     = 8 * (2 + CHECK_LEN);
    localparam int RUN_CYCLES = 5 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + 20;

    logic                     CORE_CLK;
    logic                     CORE_RST_X;
    logic                     i_init_start, i_init_done;
    logic                     i_btn_u, i_btn_d, i_btn_c, i_btn_l, i_btn_r;
    logic                     i_kbd_we, i_mouse_we;
    logic [7:0]               i_kbd_data, i_mouse_data;
    logic [`PANEL_WORD_W-1:0] i_pc, i_ir;
    priv_e                    i_priv;
    logic [7:0]               o_seg;
    logic [`PANEL_DIGITS-1:0] o_an;
    logic [2:0]               o_led_rgb;
    logic                     o_heartbeat;
    int                       test_id;
    logic                     check_en, test_end;
    int                       tests_run, tests_failed;

    status_panel_top dut_i (.*);

    panel_checker chk_i (
        .CORE_CLK(CORE_CLK), .CORE_RST_X(CORE_RST_X),
        .i_btn_u(i_btn_u), .i_btn_d(i_btn_d), .i_btn_c(i_btn_c),
        .i_btn_l(i_btn_l), .i_btn_r(i_btn_r),
        .i_kbd_we(i_kbd_we), .i_kbd_data(i_kbd_data),
        .i_mouse_we(i_mouse_we), .i_mouse_data(i_mouse_data),
        .i_pc(i_pc), .i_ir(i_ir), .i_priv(i_priv),
        .i_seg(o_seg), .i_an(o_an), .i_led_rgb(o_led_rgb), .i_heartbeat(o_heartbeat),
        .i_test(test_id), .i_check_en(check_en), .i_test_end(test_end),
        .o_tests_run(tests_run), .o_tests_failed(tests_failed)
    );

    always #20 CORE_CLK = ~CORE_CLK;

    // let the display settle, then compare two full frames
    task automatic hold_and_check();
        repeat (FRAME + 2) @(posedge CORE_CLK);
        check_en <= 1'b1;
        repeat (2 * FRAME) @(posedge CORE_CLK);
        check_en <= 1'b0;
    endtask

    task automatic next_test(input int id);
        test_end <= 1'b1;
        @(posedge CORE_CLK);
        test_end <= 1'b0;
        test_id  <= id;
        @(posedge CORE_CLK);
    endtask

    initial begin
        int sel;
        int zb;
        void'($urandom(93));
        CORE_CLK = 1'b0;
        CORE_RST_X = 1'b0;
        i_init_start = 1'b0;
        i_init_done = 1'b0;
        {i_btn_u, i_btn_d, i_btn_c, i_btn_l, i_btn_r} = '0;
        i_kbd_we = 1'b0;
        i_kbd_data = '0;
        i_mouse_we = 1'b0;
        i_mouse_data = '0;
        i_pc = '0;
        i_ir = '0;
        i_priv = PRIV_U;
        test_id = 1;
        check_en = 1'b0;
        test_end = 1'b0;
        repeat (5) @(posedge CORE_CLK);
        CORE_RST_X <= 1'b1;

        hold_and_check();  // splash
        next_test(2);

        i_init_start <= 1'b1;
        repeat (FRAME + 4) @(posedge CORE_CLK);
        check_en <= 1'b1;
        repeat (16 * `PANEL_SCROLL_DIV) @(posedge CORE_CLK);
        check_en <= 1'b0;
        next_test(3);

        i_init_done <= 1'b1;
        for (int b = 0; b < 6; b++) begin
            repeat (4 + $urandom % 16) begin
                @(posedge CORE_CLK);
                i_kbd_we     <= 1'($urandom % 2);
                i_kbd_data   <= 8'($urandom);
                i_mouse_we   <= 1'($urandom % 2);
                i_mouse_data <= 8'($urandom);
            end
            @(posedge CORE_CLK);
            i_kbd_we   <= 1'b0;
            i_mouse_we <= 1'b0;
            hold_and_check();
        end
        next_test(4);

        for (int r = 0; r < 10; r++) begin
            sel = $urandom % 4;
            zb  = 1 + $urandom % 7;  // at least one of u, d, c when sel is 0
            @(posedge CORE_CLK);
            i_pc    <= $urandom;
            i_ir    <= $urandom;
            i_btn_u <= (sel == 0) && zb[2];
            i_btn_d <= (sel == 0) && zb[1];
            i_btn_c <= (sel == 0) && zb[0];
            i_btn_l <= (sel == 1) || ((sel == 0) && ($urandom % 2 == 0));
            i_btn_r <= (sel == 2) || ((sel != 3) && ($urandom % 2 == 0));
            hold_and_check();
        end
        next_test(5);

        {i_btn_u, i_btn_d, i_btn_c, i_btn_l, i_btn_r} <= '0;
        for (int r = 0; r < 8; r++) begin
            @(posedge CORE_CLK);
            i_priv <= priv_e'((r < 4) ? r : $urandom % 4);  // every value at least once
            hold_and_check();
        end
        next_test(6);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * 40);
        $display("timeout: the test sequence did not complete in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: tests/panel_checker.sv
`include "panel_defines.svh"

module panel_checker
    import panel_pkg::*;
(
    input  logic        CORE_CLK,
    input  logic        CORE_RST_X,
    input  logic        i_btn_u, i_btn_d, i_btn_c, i_btn_l, i_btn_r,
    input  logic        i_kbd_we,
    input  logic [7:0]  i_kbd_data,
    input  logic        i_mouse_we,
    input  logic [7:0]  i_mouse_data,
    input  logic [31:0] i_pc,
    input  logic [31:0] i_ir,
    input  priv_e       i_priv,
    input  logic [7:0]  i_seg,
    input  logic [7:0]  i_an,
    input  logic [2:0]  i_led_rgb,
    input  logic        i_heartbeat,
    input  int          i_test,
    input  logic        i_check_en,
    input  logic        i_test_end,
    output int          o_tests_run,
    output int          o_tests_failed
);

    logic [7:0]  hex_tab [16];
    logic [7:0]  splash_tab [8];   // indexed by digit
    logic [7:0]  load_tab [16];
    string       test_names [7];
    logic [31:0] hist;             // model of the input history
    logic [31:0] word;
    logic [7:0]  exp_seg;
    logic [2:0]  exp_rgb;
    logic        after_rst, hb_prev, blue_prev;
    int          cyc, hb_last, hb_toggles, errs, d;
    int          scroll_p, scroll_steps, blue_first, en_cyc, lit;

    initial begin
        hex_tab = '{8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
                    8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47};
        splash_tab = '{`PANEL_GLYPH_C, `PANEL_GLYPH_O, `PANEL_GLYPH_R, `PANEL_GLYPH_P,
                       `PANEL_GLYPH_H, `PANEL_GLYPH_C, `PANEL_GLYPH_R, `PANEL_GLYPH_A};
        load_tab = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
                     `PANEL_GLYPH_L, `PANEL_GLYPH_O, `PANEL_GLYPH_LA, `PANEL_GLYPH_D,
                     `PANEL_GLYPH_I, `PANEL_GLYPH_N, `PANEL_GLYPH_G,
                     `PANEL_GLYPH_DOT, `PANEL_GLYPH_DOT};
        test_names = '{"none", "splash_reset", "loading_scroll", "history_hex",
                       "button_select", "priv_heartbeat", "none"};
        o_tests_run = 0;
        o_tests_failed = 0;
        errs = 0;
        scroll_p = 0;
        scroll_steps = 0;
        blue_first = -1;
        en_cyc = 0;
        lit = 0;
    end

    task automatic report_value(input string what, input logic [31:0] exp, act);
        $display("Error: test %s %s expected %h actual %h", test_names[i_test], what, exp, act);
        errs++;
    endtask

    task automatic report_text(input string what);
        $display("Error: test %s failed, %s", test_names[i_test], what);
        errs++;
    endtask

    // index of the only low anode or -1
    function automatic int anode_digit(input logic [7:0] an);
        int n = 0;
        int idx = -1;
        for (int i = 0; i < 8; i++) begin
            if (!an[i]) begin
                n++;
                idx = i;
            end
        end
        return (n == 1) ? idx : -1;
    endfunction

    task automatic finish_test();
        if (i_test == 2 && (blue_first < 0 || blue_first > 4096))
            report_text("the blue channel did not change within 4096 cycles");
        if (i_test == 2 && scroll_steps < 10)
            report_text("the loading message did not scroll far enough");
        if (i_test == 5 && hb_toggles < 2)
            report_text("the heartbeat did not toggle");
        $display("test %0d %s: %s (%0d errors)", i_test, test_names[i_test],
                 (errs == 0) ? "passed" : "failed", errs);
        o_tests_run++;
        if (errs != 0) o_tests_failed++;
        errs = 0;
        en_cyc = 0;
        lit = 0;
        hb_toggles = 0;
    endtask

    always @(negedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hist = '0;
            after_rst = 1'b1;
            cyc = 0;
            hb_prev = 1'b0;
            hb_last = -1;
            hb_toggles = 0;
        end else begin
            cyc++;
            if (after_rst) begin
                if (i_an !== 8'hff) report_value("reset anodes", 32'hff, {24'h0, i_an});
                if (i_seg !== 8'hff) report_value("reset segments", 32'hff, {24'h0, i_seg});
                if (i_led_rgb !== 3'b000) report_value("reset rgb", 0, {29'h0, i_led_rgb});
                after_rst = 1'b0;
            end
            if (i_heartbeat !== hb_prev) begin
                if (hb_last >= 0 && cyc - hb_last != `PANEL_HEARTBEAT_DIV)
                    report_value("heartbeat interval", `PANEL_HEARTBEAT_DIV, cyc - hb_last);
                hb_last = cyc;
                hb_toggles++;
                hb_prev = i_heartbeat;
            end
            if (i_check_en) begin
                d = anode_digit(i_an);
                if (d < 0) report_text("the anode output does not select exactly one digit");
                else if (i_test == 1) begin
                    exp_seg = ~splash_tab[d];
                    if (i_seg !== exp_seg) report_value("splash glyph", exp_seg, i_seg);
                    if (i_led_rgb !== 3'b000) report_value("splash rgb", 0, i_led_rgb);
                end else if (i_test == 2) begin
                    if (en_cyc == 0) blue_prev = i_led_rgb[2];
                    if (i_led_rgb[2] !== blue_prev && blue_first < 0) blue_first = en_cyc;
                    blue_prev = i_led_rgb[2];
                    exp_seg = ~load_tab[(scroll_p + 7 - d) & 15];
                    if (i_seg === exp_seg) begin
                        // still on the current scroll position
                    end else if (i_seg === ~load_tab[(scroll_p + 8 - d) & 15]) begin
                        scroll_p = (scroll_p + 1) & 15;
                        scroll_steps++;
                    end else begin
                        report_value("loading glyph", exp_seg, i_seg);
                    end
                end else if (i_test == 3 || i_test == 4) begin
                    if (i_btn_u || i_btn_d || i_btn_c) word = '0;
                    else if (i_btn_l) word = i_pc;
                    else if (i_btn_r) word = i_ir;
                    else word = hist;
                    exp_seg = ~hex_tab[word[d*4 +: 4]];
                    if (i_seg !== exp_seg) report_value("hex glyph", exp_seg, i_seg);
                end else if (i_test == 5) begin
                    case (2'(i_priv))
                        2'd0:    exp_rgb = 3'b100;
                        2'd1:    exp_rgb = 3'b010;
                        2'd3:    exp_rgb = 3'b001;
                        default: exp_rgb = 3'b000;
                    endcase
                    if (i_led_rgb != 3'b000) begin
                        lit++;
                        if (i_led_rgb !== exp_rgb) report_value("priv colour", exp_rgb, i_led_rgb);
                    end
                    if (en_cyc % 16 == 15) begin
                        if (lit != ((exp_rgb != 3'b000) ? 1 : 0))
                            report_value("lit cycles per window", (exp_rgb != 0) ? 1 : 0, lit);
                        lit = 0;
                    end
                end
                en_cyc++;
            end
            // strobes seen here land in the DUT on the next rising edge
            if (i_kbd_we) hist = {hist[31:16], hist[7:0], i_kbd_data};
            if (i_mouse_we) hist = {hist[23:16], i_mouse_data, hist[15:0]};
            if (i_test_end) finish_test();
        end
    end

endmodule

// File: rtl/status_panel_top.sv
`include "panel_defines.svh"

module status_panel_top
    import panel_pkg::*;
(
    input  logic                      CORE_CLK,
    input  logic                      CORE_RST_X,
    input  logic                      i_init_start,
    input  logic                      i_init_done,
    input  logic                      i_btn_u,
    input  logic                      i_btn_d,
    input  logic                      i_btn_c,
    input  logic                      i_btn_l,
    input  logic                      i_btn_r,
    input  logic                      i_kbd_we,
    input  logic [7:0]                i_kbd_data,
    input  logic                      i_mouse_we,
    input  logic [7:0]                i_mouse_data,
    input  logic [`PANEL_WORD_W-1:0]  i_pc,
    input  logic [`PANEL_WORD_W-1:0]  i_ir,
    input  priv_e                     i_priv,
    output logic [7:0]                o_seg,
    output logic [`PANEL_DIGITS-1:0]  o_an,
    output logic [2:0]                o_led_rgb,
    output logic                      o_heartbeat
);

    disp_mode_e                   w_mode;
    logic                         w_digit_tick;
    logic [2:0]                   w_digit;
    logic [3:0]                   w_scroll_pos;
    logic [`PANEL_BLINK_BITS-1:0] w_blink_phase;
    logic [`PANEL_WORD_W-1:0]     w_word;

    disp_mode_fsm u_mode (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_init_start (i_init_start),
        .i_init_done  (i_init_done),
        .o_mode       (w_mode)
    );

    display_timer u_timer (
        .CORE_CLK      (CORE_CLK),
        .CORE_RST_X    (CORE_RST_X),
        .i_mode        (w_mode),
        .o_digit_tick  (w_digit_tick),
        .o_digit       (w_digit),
        .o_scroll_pos  (w_scroll_pos),
        .o_blink_phase (w_blink_phase),
        .o_heartbeat   (o_heartbeat)
    );

    display_word_select u_word (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_btn_u      (i_btn_u),
        .i_btn_d      (i_btn_d),
        .i_btn_c      (i_btn_c),
        .i_btn_l      (i_btn_l),
        .i_btn_r      (i_btn_r),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .i_pc         (i_pc),
        .i_ir         (i_ir),
        .o_word       (w_word)
    );

    seg_digit_driver u_seg (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_mode       (w_mode),
        .i_digit_tick (w_digit_tick),
        .i_digit      (w_digit),
        .i_scroll_pos (w_scroll_pos),
        .i_word       (w_word),
        .o_seg        (o_seg),
        .o_an         (o_an)
    );

    rgb_status_led u_rgb (
        .CORE_CLK      (CORE_CLK),
        .CORE_RST_X    (CORE_RST_X),
        .i_mode        (w_mode),
        .i_priv        (i_priv),
        .i_blink_phase (w_blink_phase),
        .o_led_rgb     (o_led_rgb)
    );

endmodule

// File: rtl/rgb_status_led.sv
`include "panel_defines.svh"

module rgb_status_led
    import panel_pkg::*;
(
    input  logic                          CORE_CLK,
    input  logic                          CORE_RST_X,
    input  disp_mode_e                    i_mode,
    input  priv_e                         i_priv,
    input  logic [`PANEL_BLINK_BITS-1:0]  i_blink_phase,
    output logic [2:0]                    o_led_rgb  // {blue, green, red}
);

    localparam int PW = `PANEL_PWM_BITS;

    // channel 2 blue, 1 green, 0 red
    localparam logic [2:0][PW:0] DUTY_STEP = {13'd2, 13'd3, 13'd5};
    localparam logic [2:0][PW:0] DUTY_INIT = {13'd0, 13'd64, 13'd512};

    logic [PW-1:0]     r_frame;
    logic [2:0][PW:0]  r_duty;   // top bit selects ramp up or down
    logic [2:0]        r_pwm;
    logic [2:0]        w_priv_rgb;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_frame <= '0;
            r_duty  <= DUTY_INIT;
            r_pwm   <= '0;
        end else begin
            r_frame <= r_frame + 1'b1;
            for (int ch = 0; ch < 3; ch++) begin
                if (r_frame == '0) begin
                    r_duty[ch] <= r_duty[ch] + DUTY_STEP[ch];  // once per frame
                end
                r_pwm[ch] <= r_duty[ch][PW] ? (r_duty[ch][PW-1:0] < r_frame)
                                            : (r_duty[ch][PW-1:0] >= r_frame);
            end
        end
    end

    always_comb begin
        case (i_priv)
            PRIV_U:  w_priv_rgb = 3'b100;  // blue
            PRIV_S:  w_priv_rgb = 3'b010;  // green
            PRIV_M:  w_priv_rgb = 3'b001;  // red
            default: w_priv_rgb = 3'b000;
        endcase
    end

    always_comb begin
        case (i_mode)
            MODE_LOAD: o_led_rgb = r_pwm;
            MODE_RUN:  o_led_rgb = (i_blink_phase == '0) ? w_priv_rgb : 3'b000;
            default:   o_led_rgb = 3'b000;
        endcase
    end

endmodule

// File: rtl/seg_digit_driver.sv
`include "panel_defines.svh"

module seg_digit_driver
    import panel_pkg::*;
(
    input  logic                      CORE_CLK,
    input  logic                      CORE_RST_X,
    input  disp_mode_e                i_mode,
    input  logic                      i_digit_tick,
    input  logic [2:0]                i_digit,
    input  logic [3:0]                i_scroll_pos,
    input  logic [`PANEL_WORD_W-1:0]  i_word,
    output logic [7:0]                o_seg,   // active low
    output logic [`PANEL_DIGITS-1:0]  o_an     // active low
);

    logic [3:0] w_nibble;
    logic [3:0] w_load_idx;
    logic [7:0] w_glyph;
    logic       r_started;  // set by the first tick

    function automatic logic [7:0] hex_glyph(input logic [3:0] nib);
        case (nib)
            4'h0:    return 8'h7e;
            4'h1:    return 8'h30;
            4'h2:    return 8'h6d;
            4'h3:    return 8'h79;
            4'h4:    return 8'h33;
            4'h5:    return 8'h5b;
            4'h6:    return 8'h5f;
            4'h7:    return 8'h70;
            4'h8:    return 8'h7f;
            4'h9:    return 8'h7b;
            4'ha:    return 8'h77;
            4'hb:    return 8'h1f;
            4'hc:    return 8'h4e;
            4'hd:    return 8'h3d;
            4'he:    return 8'h4f;
            default: return 8'h47;
        endcase
    endfunction

    // "ArchProc", leftmost digit is 7
    function automatic logic [7:0] splash_glyph(input logic [2:0] dig);
        case (dig)
            3'd7:    return `PANEL_GLYPH_A;
            3'd6:    return `PANEL_GLYPH_R;
            3'd5:    return `PANEL_GLYPH_C;
            3'd4:    return `PANEL_GLYPH_H;
            3'd3:    return `PANEL_GLYPH_P;
            3'd2:    return `PANEL_GLYPH_R;
            3'd1:    return `PANEL_GLYPH_O;
            default: return `PANEL_GLYPH_C;
        endcase
    endfunction

    // 16-entry message ring: 7 blanks, "Loading", two dots
    function automatic logic [7:0] load_glyph(input logic [3:0] idx);
        case (idx)
            4'd7:    return `PANEL_GLYPH_L;
            4'd8:    return `PANEL_GLYPH_O;
            4'd9:    return `PANEL_GLYPH_LA;
            4'd10:   return `PANEL_GLYPH_D;
            4'd11:   return `PANEL_GLYPH_I;
            4'd12:   return `PANEL_GLYPH_N;
            4'd13:   return `PANEL_GLYPH_G;
            4'd14,
            4'd15:   return `PANEL_GLYPH_DOT;
            default: return 8'h00;
        endcase
    endfunction

    assign w_nibble   = i_word[{i_digit, 2'b00} +: 4];
    assign w_load_idx = i_scroll_pos + 4'd7 - {1'b0, i_digit};  // mod 16

    always_comb begin
        case (i_mode)
            MODE_RUN:  w_glyph = hex_glyph(w_nibble);
            MODE_LOAD: w_glyph = load_glyph(w_load_idx);
            default:   w_glyph = splash_glyph(i_digit);
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_seg     <= '1;
            o_an      <= '1;  // all digits off
            r_started <= 1'b0;
        end else if (i_digit_tick) begin
            o_seg     <= ~w_glyph;
            o_an      <= ~(`PANEL_DIGITS'(1) << i_digit);
            r_started <= 1'b1;
        end
    end

    // from the first slot on, exactly one digit is driven
    a_one_anode: assert property (
        @(posedge CORE_CLK) disable iff (!CORE_RST_X)
        r_started |-> $onehot(~o_an)
    );

endmodule

// File: rtl/display_word_select.sv
`include "panel_defines.svh"

module display_word_select (
    input  logic                      CORE_CLK,
    input  logic                      CORE_RST_X,
    input  logic                      i_btn_u,
    input  logic                      i_btn_d,
    input  logic                      i_btn_c,
    input  logic                      i_btn_l,
    input  logic                      i_btn_r,
    input  logic                      i_kbd_we,
    input  logic [7:0]                i_kbd_data,
    input  logic                      i_mouse_we,
    input  logic [7:0]                i_mouse_data,
    input  logic [`PANEL_WORD_W-1:0]  i_pc,
    input  logic [`PANEL_WORD_W-1:0]  i_ir,
    output logic [`PANEL_WORD_W-1:0]  o_word
);

    // last two keyboard bytes low, last two mouse bytes high
    logic [`PANEL_WORD_W-1:0] r_history;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_history <= '0;
        end else begin
            if (i_kbd_we) begin
                r_history[15:8] <= r_history[7:0];
                r_history[7:0]  <= i_kbd_data;
            end
            if (i_mouse_we) begin
                r_history[31:24] <= r_history[23:16];
                r_history[23:16] <= i_mouse_data;
            end
        end
    end

    // button priority: u/d/c blank, then pc, then ir, else history
    always_comb begin
        if (i_btn_u || i_btn_d || i_btn_c) begin
            o_word = '0;
        end else if (i_btn_l) begin
            o_word = i_pc;
        end else if (i_btn_r) begin
            o_word = i_ir;
        end else begin
            o_word = r_history;
        end
    end

endmodule

// File: rtl/display_timer.sv
`include "panel_defines.svh"

module display_timer
    import panel_pkg::*;
(
    input  logic                          CORE_CLK,
    input  logic                          CORE_RST_X,
    input  disp_mode_e                    i_mode,
    output logic                          o_digit_tick,
    output logic [2:0]                    o_digit,
    output logic [3:0]                    o_scroll_pos,
    output logic [`PANEL_BLINK_BITS-1:0]  o_blink_phase,
    output logic                          o_heartbeat
);

    localparam int SCAN_W   = $clog2(`PANEL_SCAN_DIV);
    localparam int SCROLL_W = $clog2(`PANEL_SCROLL_DIV);
    localparam int HB_W     = $clog2(`PANEL_HEARTBEAT_DIV);

    logic [SCAN_W-1:0]   r_scan_cnt;
    logic [SCROLL_W-1:0] r_scroll_cnt;
    logic [HB_W-1:0]     r_hb_cnt;
    logic                w_scroll_wrap;
    logic                w_hb_wrap;

    assign o_digit_tick  = (r_scan_cnt == SCAN_W'(`PANEL_SCAN_DIV - 1));
    assign w_scroll_wrap = (r_scroll_cnt == SCROLL_W'(`PANEL_SCROLL_DIV - 1));
    assign w_hb_wrap     = (r_hb_cnt == HB_W'(`PANEL_HEARTBEAT_DIV - 1));

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_scan_cnt    <= '0;
            o_digit       <= '0;
            r_scroll_cnt  <= '0;
            o_scroll_pos  <= '0;
            o_blink_phase <= '0;
            r_hb_cnt      <= '0;
            o_heartbeat   <= 1'b0;
        end else begin
            // digit scan
            r_scan_cnt <= o_digit_tick ? '0 : r_scan_cnt + 1'b1;
            if (o_digit_tick) begin
                o_digit <= o_digit + 1'b1;
            end

            // scroll only moves while loading
            if (i_mode == MODE_LOAD) begin
                r_scroll_cnt <= w_scroll_wrap ? '0 : r_scroll_cnt + 1'b1;
                if (w_scroll_wrap) begin
                    o_scroll_pos <= o_scroll_pos + 1'b1;  // wraps mod 16
                end
            end

            o_blink_phase <= o_blink_phase + 1'b1;  // free running

            r_hb_cnt <= w_hb_wrap ? '0 : r_hb_cnt + 1'b1;
            if (w_hb_wrap) begin
                o_heartbeat <= ~o_heartbeat;
            end
        end
    end

    // each digit slot is opened by a single-cycle tick
    a_tick_pulse: assert property (
        @(posedge CORE_CLK) disable iff (!CORE_RST_X)
        o_digit_tick |=> !o_digit_tick
    );

endmodule

// File: rtl/disp_mode_fsm.sv
module disp_mode_fsm
    import panel_pkg::*;
(
    input  logic       CORE_CLK,
    input  logic       CORE_RST_X,
    input  logic       i_init_start,
    input  logic       i_init_done,
    output disp_mode_e o_mode
);

    disp_mode_e r_mode;
    disp_mode_e w_mode_nxt;

    always_comb begin
        w_mode_nxt = r_mode;
        case (r_mode)
            MODE_SPLASH: begin
                // done wins if the loader finishes before start is seen
                if (i_init_done) begin
                    w_mode_nxt = MODE_RUN;
                end else if (i_init_start) begin
                    w_mode_nxt = MODE_LOAD;
                end
            end
            MODE_LOAD: begin
                if (i_init_done) begin
                    w_mode_nxt = MODE_RUN;
                end
            end
            MODE_RUN:    w_mode_nxt = MODE_RUN;  // held until reset
            default:     w_mode_nxt = MODE_SPLASH;
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_mode <= MODE_SPLASH;
        end else begin
            r_mode <= w_mode_nxt;
        end
    end

    assign o_mode = r_mode;

    // once running, the panel never falls back to splash or loading
    a_run_sticky: assert property (
        @(posedge CORE_CLK) disable iff (!CORE_RST_X)
        (o_mode == MODE_RUN) |=> (o_mode == MODE_RUN)
    );

endmodule

// File: rtl/panel_pkg.sv
package panel_pkg;

    // board phase as seen by the panel
    typedef enum logic [1:0] {
        MODE_SPLASH = 2'd0,  // before boot loading starts
        MODE_LOAD   = 2'd1,  // boot image being loaded
        MODE_RUN    = 2'd2   // cpu running
    } disp_mode_e;

    // privilege level of the running hart
    // value 2 is reserved and shows no colour
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

endpackage

// File: rtl/panel_defines.svh
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// scan and blink timing, in core clock cycles
`define PANEL_SCAN_DIV       16     // cycles per digit slot
`define PANEL_SCROLL_DIV     512    // cycles per scroll step while loading
`define PANEL_HEARTBEAT_DIV  100    // cycles between heartbeat toggles

// counter widths
`define PANEL_PWM_BITS       12     // breathing frame counter
`define PANEL_BLINK_BITS     4      // led lit one cycle in 16

// display geometry
`define PANEL_DIGITS         8
`define PANEL_WORD_W         32

// active-high segment patterns, bit 7 is the dot
`define PANEL_GLYPH_A        8'h77
`define PANEL_GLYPH_R        8'h05  // lower case r
`define PANEL_GLYPH_C        8'h0d  // lower case c
`define PANEL_GLYPH_H        8'h17
`define PANEL_GLYPH_P        8'h67
`define PANEL_GLYPH_O        8'h1d  // lower case o

// loading message
`define PANEL_GLYPH_L        8'h0e
`define PANEL_GLYPH_LA       8'h7d  // lower case a with top bar
`define PANEL_GLYPH_D        8'h3d
`define PANEL_GLYPH_I        8'h10
`define PANEL_GLYPH_N        8'h15
`define PANEL_GLYPH_G        8'hfb
`define PANEL_GLYPH_DOT      8'h80

`endif
